// File: hw/ni_pkg.sv
package ni_pkg;

	// Flit geometry
	localparam int FLIT_PAYLOAD_W = 32;

	// Virtual channels at the router port
	localparam int VC_COUNT    = 2;
	localparam int VC_REQUEST  = 0;
	localparam int VC_RESPONSE = 1;

	// Fixed packet length per channel, in flits
	localparam int REQUEST_FLITS  = 2;
	localparam int RESPONSE_FLITS = 3;

	typedef logic vc_id_t;

	// Mesh coordinates of a tile
	typedef struct packed {
		logic [1:0] x;
		logic [1:0] y;
	} tile_address_t;

	// Unit inside the destination tile
	typedef enum logic {
		UNIT_CC,
		UNIT_DC
	} target_unit_t;

	typedef enum logic [1:0] {
		HEAD,
		BODY,
		TAIL
	} flit_type_t;

	// One flit on the router link, 40 bits
	typedef struct packed {
		flit_type_t                flit_type;
		vc_id_t                    vc;
		tile_address_t             destination;
		target_unit_t              target_unit;
		logic [FLIT_PAYLOAD_W-1:0] payload;
	} flit_t;

	// Coherence request, two flits
	typedef struct packed {
		logic [31:0]   address;
		logic [3:0]    opcode;
		tile_address_t requestor;
		logic [23:0]   tag;
	} request_message_t;

	// Coherence response, three flits
	typedef struct packed {
		logic [31:0]   address;
		logic [3:0]    opcode;
		logic [15:0]   sharers;
		tile_address_t source;
		logic [39:0]   data;
	} response_message_t;

endpackage

// File: hw/ni_packet_fifo.sv
module ni_packet_fifo #(
	parameter int WIDTH       = 32,
	parameter int DEPTH       = 4,
	parameter int ALMOST_FULL = DEPTH - 1
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             push,
	input  logic [WIDTH-1:0] push_data,
	input  logic             pop,
	output logic [WIDTH-1:0] pop_data,
	output logic             empty,
	output logic             full,
	output logic             almost_full
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] storage [DEPTH];
	logic [PTR_W-1:0] read_ptr;
	logic [PTR_W-1:0] write_ptr;
	logic [PTR_W:0]   count;
	logic             do_push;
	logic             do_pop;

	// Push into a full FIFO or pop from an empty one is ignored
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	assign empty       = (count == '0);
	assign full        = (count == (PTR_W + 1)'(DEPTH));
	assign almost_full = (count >= (PTR_W + 1)'(ALMOST_FULL));

	// Head entry is always visible
	assign pop_data = storage[read_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			storage[write_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			read_ptr  <= '0;
			write_ptr <= '0;
			count     <= '0;
		end else begin
			// Pointers wrap at DEPTH, which need not be a power of two
			if (do_push) begin
				write_ptr <= (write_ptr == PTR_W'(DEPTH - 1)) ? '0 : write_ptr + 1'b1;
			end
			if (do_pop) begin
				read_ptr <= (read_ptr == PTR_W'(DEPTH - 1)) ? '0 : read_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: hw/ni_round_robin_arbiter.sv
module ni_round_robin_arbiter #(
	parameter int SIZE       = 2,
	parameter bit GRANT_HOLD = 1'b0
) (
	input  logic            clk,
	input  logic            reset,
	input  logic [SIZE-1:0] requests,
	output logic [SIZE-1:0] grant_oh
);
	localparam int INDEX_W = (SIZE > 1) ? $clog2(SIZE) : 1;

	logic [INDEX_W-1:0] last_index;
	logic [INDEX_W-1:0] grant_index;
	logic [SIZE-1:0]    rotate_grant;
	logic [SIZE-1:0]    held_grant;
	logic               hold_active;

	// Scan from farthest to nearest, the nearest requester after the last winner wins
	always_comb begin
		int candidate;
		rotate_grant = '0;
		for (int offset = SIZE; offset > 0; offset--) begin
			candidate = (int'(last_index) + offset) % SIZE;
			if (requests[candidate]) begin
				rotate_grant            = '0;
				rotate_grant[candidate] = 1'b1;
			end
		end
	end

	// Keep the previous winner while it still asks
	assign hold_active = GRANT_HOLD && (|(held_grant & requests));
	assign grant_oh    = hold_active ? held_grant : rotate_grant;

	// One-hot to index of the current winner
	always_comb begin
		grant_index = last_index;
		for (int i = 0; i < SIZE; i++) begin
			if (grant_oh[i]) begin
				grant_index = INDEX_W'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			// Requester 0 has top priority out of reset
			last_index <= INDEX_W'(SIZE - 1);
			held_grant <= '0;
		end else begin
			held_grant <= grant_oh;
			if (|grant_oh) begin
				last_index <= grant_index;
			end
		end
	end

endmodule

// File: hw/ni_core_to_net.sv
module ni_core_to_net
	import ni_pkg::*;
#(
	parameter int X_ADDR       = 1,
	parameter int Y_ADDR       = 1,
	parameter int VCID         = VC_REQUEST,
	parameter int BODY_W       = 64,
	parameter int PACKET_FLITS = REQUEST_FLITS,
	parameter int FIFO_DEPTH   = 4
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              packet_valid,
	input  logic [BODY_W-1:0] packet_body,
	input  tile_address_t     packet_destination,
	input  target_unit_t      packet_target,
	output logic              packet_fifo_full,
	output logic              packet_pending,
	input  logic              flit_grant,
	output flit_t             flit_out
);
	localparam int INDEX_W     = (PACKET_FLITS > 1) ? $clog2(PACKET_FLITS) : 1;
	localparam int COORD_LIMIT = 1 << ($bits(tile_address_t) / 2);

	// Everything needed to build the flits of one packet
	typedef struct packed {
		logic [BODY_W-1:0] body;
		tile_address_t     destination;
		target_unit_t      target;
	} packet_entry_t;

	packet_entry_t      push_entry;
	packet_entry_t      head_entry;
	logic               fifo_empty;
	logic               last_flit;
	logic [INDEX_W-1:0] flit_index;

	// Own tile must be addressable in the mesh
	if (X_ADDR < 0 || X_ADDR >= COORD_LIMIT || Y_ADDR < 0 || Y_ADDR >= COORD_LIMIT) begin : g_tile
		$error("Tile coordinates do not fit tile_address_t");
	end

	assign push_entry = '{
		body:        packet_body,
		destination: packet_destination,
		target:      packet_target
	};

	ni_packet_fifo #(
		.WIDTH       ($bits(packet_entry_t)),
		.DEPTH       (FIFO_DEPTH),
		.ALMOST_FULL (FIFO_DEPTH - 1)
	) packet_fifo (
		.clk         (clk),
		.reset       (reset),
		.push        (packet_valid),
		.push_data   (push_entry),
		// Head packet leaves once its tail flit is sent
		.pop         (flit_grant & last_flit),
		.pop_data    (head_entry),
		.empty       (fifo_empty),
		.full        (packet_fifo_full),
		.almost_full ()
	);

	assign packet_pending = ~fifo_empty;
	assign last_flit      = (flit_index == INDEX_W'(PACKET_FLITS - 1));

	// Slice of the head packet for the current position, lowest word first
	always_comb begin
		flit_out.vc          = vc_id_t'(VCID);
		flit_out.destination = head_entry.destination;
		flit_out.target_unit = head_entry.target;
		flit_out.payload     = head_entry.body[flit_index * FLIT_PAYLOAD_W +: FLIT_PAYLOAD_W];
		if (flit_index == '0) begin
			flit_out.flit_type = HEAD;
		end else if (last_flit) begin
			flit_out.flit_type = TAIL;
		end else begin
			flit_out.flit_type = BODY;
		end
	end

	// Position inside the packet, advances on each granted flit
	always_ff @(posedge clk) begin
		if (reset) begin
			flit_index <= '0;
		end else if (flit_grant) begin
			flit_index <= last_flit ? '0 : flit_index + 1'b1;
		end
	end

endmodule

// File: hw/ni_net_to_core.sv
module ni_net_to_core
	import ni_pkg::*;
#(
	parameter int           VCID         = VC_REQUEST,
	parameter target_unit_t UNIT         = UNIT_DC,
	parameter int           BODY_W       = 64,
	parameter int           PACKET_FLITS = REQUEST_FLITS,
	parameter int           FIFO_DEPTH   = 4
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              router_flit_valid,
	input  flit_t             router_flit_in,
	output logic [BODY_W-1:0] packet_out,
	output logic              packet_valid,
	input  logic              packet_consumed,
	output logic              stop
);
	// Holds every word of the packet except the tail one
	localparam int ASSEMBLY_W = (PACKET_FLITS - 1) * FLIT_PAYLOAD_W;

	logic [ASSEMBLY_W-1:0] assembly;
	logic [BODY_W-1:0]     assembled_packet;
	logic                  flit_accept;
	logic                  packet_done;
	logic                  fifo_empty;

	// Only flits of this channel and this unit are ours
	assign flit_accept = router_flit_valid
		&& (router_flit_in.vc == vc_id_t'(VCID))
		&& (router_flit_in.target_unit == UNIT);

	assign packet_done = flit_accept && (router_flit_in.flit_type == TAIL);

	// Newest word enters at the top, so the first word ends up lowest
	assign assembled_packet = {router_flit_in.payload, assembly};

	always_ff @(posedge clk) begin
		if (flit_accept) begin
			assembly <= assembled_packet[BODY_W-1 -: ASSEMBLY_W];
		end
	end

	// Completed packet goes straight into the FIFO on its tail
	ni_packet_fifo #(
		.WIDTH       (BODY_W),
		.DEPTH       (FIFO_DEPTH),
		.ALMOST_FULL (FIFO_DEPTH - 1)
	) packet_fifo (
		.clk         (clk),
		.reset       (reset),
		.push        (packet_done),
		.push_data   (assembled_packet),
		.pop         (packet_consumed),
		.pop_data    (packet_out),
		.empty       (fifo_empty),
		.full        (),
		// One slot stays free for a packet already in flight
		.almost_full (stop)
	);

	assign packet_valid = ~fifo_empty;

endmodule

// File: hw/network_interface_core.sv
module network_interface_core
	import ni_pkg::*;
#(
	parameter int X_ADDR = 1,
	parameter int Y_ADDR = 1
) (
	input  logic                clk,
	input  logic                reset,

	// Cache controller request injection
	input  request_message_t    l1d_request,
	input  logic                l1d_request_valid,
	input  tile_address_t       l1d_request_destination,
	output logic                ni_request_network_available,

	// Cache controller response injection
	input  response_message_t   l1d_response,
	input  logic                l1d_response_valid,
	input  tile_address_t       l1d_response_destination,
	input  target_unit_t        l1d_response_target,
	output logic                ni_response_cc_network_available,

	// Directory response injection, always toward a cache controller
	input  response_message_t   dc_response,
	input  logic                dc_response_valid,
	input  tile_address_t       dc_response_destination,
	output logic                ni_response_dc_network_available,

	// Request ejection to directory
	output request_message_t    ni_request,
	output logic                ni_request_valid,
	input  logic                dc_request_consumed,

	// Response ejection to cache controller
	output response_message_t   ni_response_to_cc,
	output logic                ni_response_to_cc_valid,
	input  logic                l1d_response_to_cc_consumed,

	// Response ejection to directory
	output response_message_t   ni_response_to_dc,
	output logic                ni_response_to_dc_valid,
	input  logic                dc_response_to_dc_consumed,

	// Router port
	output flit_t               ni_flit_out,
	output logic                ni_flit_out_valid,
	input  flit_t               router_flit_in,
	input  logic                router_flit_in_valid,
	input  logic [VC_COUNT-1:0] router_credit,
	output logic [VC_COUNT-1:0] ni_credit
);
	localparam int REQUEST_FIFO_DEPTH  = 4;
	localparam int RESPONSE_FIFO_DEPTH = 4;

	// Response source indices
	localparam int DC_ID = 0;
	localparam int CC_ID = 1;

	typedef struct packed {
		logic  fifo_full;
		logic  pending;
		flit_t flit;
	} source_state_t;

	source_state_t              request_source;
	source_state_t [1:0]        response_source;
	logic          [1:0]        response_pending;
	logic          [1:0]        response_grant_oh;
	logic          [VC_COUNT-1:0] channel_pending;
	logic          [VC_COUNT-1:0] channel_requests;
	logic          [VC_COUNT-1:0] channel_grant_oh;
	flit_t         [VC_COUNT-1:0] channel_flit;
	flit_t                      granted_flit;
	logic                       cc_stop;
	logic                       dc_stop;

	// Response sources compete first, whole packets at a time
	assign response_pending = {response_source[CC_ID].pending, response_source[DC_ID].pending};

	ni_round_robin_arbiter #(
		.SIZE       (2),
		.GRANT_HOLD (1'b1)
	) response_arbiter (
		.clk      (clk),
		.reset    (reset),
		.requests (response_pending),
		.grant_oh (response_grant_oh)
	);

	assign channel_pending[VC_REQUEST]  = request_source.pending;
	assign channel_flit[VC_REQUEST]     = request_source.flit;
	assign channel_pending[VC_RESPONSE] = |response_grant_oh;
	assign channel_flit[VC_RESPONSE]    = response_grant_oh[DC_ID] ?
		response_source[DC_ID].flit : response_source[CC_ID].flit;

	// Router on/off back-pressure, a stopped channel does not compete
	assign channel_requests = channel_pending & ~router_credit;

	ni_round_robin_arbiter #(
		.SIZE       (VC_COUNT),
		.GRANT_HOLD (1'b0)
	) channel_arbiter (
		.clk      (clk),
		.reset    (reset),
		.requests (channel_requests),
		.grant_oh (channel_grant_oh)
	);

	always_comb begin
		granted_flit = channel_flit[VC_REQUEST];
		for (int v = 0; v < VC_COUNT; v++) begin
			if (channel_grant_oh[v]) begin
				granted_flit = channel_flit[v];
			end
		end
	end

	// Output flit register, the winner shows one cycle after grant
	always_ff @(posedge clk) begin
		if (reset) begin
			ni_flit_out_valid <= 1'b0;
		end else begin
			ni_flit_out_valid <= |channel_grant_oh;
		end
	end

	always_ff @(posedge clk) begin
		if (|channel_grant_oh) begin
			ni_flit_out <= granted_flit;
		end
	end

	// Injection paths
	ni_core_to_net #(
		.X_ADDR       (X_ADDR),
		.Y_ADDR       (Y_ADDR),
		.VCID         (VC_REQUEST),
		.BODY_W       ($bits(request_message_t)),
		.PACKET_FLITS (REQUEST_FLITS),
		.FIFO_DEPTH   (REQUEST_FIFO_DEPTH)
	) request_core_to_net (
		.clk                (clk),
		.reset              (reset),
		.packet_valid       (l1d_request_valid),
		.packet_body        (l1d_request),
		.packet_destination (l1d_request_destination),
		// Requests are served by the home directory
		.packet_target      (UNIT_DC),
		.packet_fifo_full   (request_source.fifo_full),
		.packet_pending     (request_source.pending),
		.flit_grant         (channel_grant_oh[VC_REQUEST]),
		.flit_out           (request_source.flit)
	);

	ni_core_to_net #(
		.X_ADDR       (X_ADDR),
		.Y_ADDR       (Y_ADDR),
		.VCID         (VC_RESPONSE),
		.BODY_W       ($bits(response_message_t)),
		.PACKET_FLITS (RESPONSE_FLITS),
		.FIFO_DEPTH   (RESPONSE_FIFO_DEPTH)
	) response_cc_core_to_net (
		.clk                (clk),
		.reset              (reset),
		.packet_valid       (l1d_response_valid),
		.packet_body        (l1d_response),
		.packet_destination (l1d_response_destination),
		.packet_target      (l1d_response_target),
		.packet_fifo_full   (response_source[CC_ID].fifo_full),
		.packet_pending     (response_source[CC_ID].pending),
		.flit_grant         (channel_grant_oh[VC_RESPONSE] & response_grant_oh[CC_ID]),
		.flit_out           (response_source[CC_ID].flit)
	);

	ni_core_to_net #(
		.X_ADDR       (X_ADDR),
		.Y_ADDR       (Y_ADDR),
		.VCID         (VC_RESPONSE),
		.BODY_W       ($bits(response_message_t)),
		.PACKET_FLITS (RESPONSE_FLITS),
		.FIFO_DEPTH   (RESPONSE_FIFO_DEPTH)
	) response_dc_core_to_net (
		.clk                (clk),
		.reset              (reset),
		.packet_valid       (dc_response_valid),
		.packet_body        (dc_response),
		.packet_destination (dc_response_destination),
		.packet_target      (UNIT_CC),
		.packet_fifo_full   (response_source[DC_ID].fifo_full),
		.packet_pending     (response_source[DC_ID].pending),
		.flit_grant         (channel_grant_oh[VC_RESPONSE] & response_grant_oh[DC_ID]),
		.flit_out           (response_source[DC_ID].flit)
	);

	assign ni_request_network_available     = ~request_source.fifo_full;
	assign ni_response_cc_network_available = ~response_source[CC_ID].fifo_full;
	assign ni_response_dc_network_available = ~response_source[DC_ID].fifo_full;

	// Ejection paths, all watch the same router flit
	ni_net_to_core #(
		.VCID         (VC_REQUEST),
		.UNIT         (UNIT_DC),
		.BODY_W       ($bits(request_message_t)),
		.PACKET_FLITS (REQUEST_FLITS),
		.FIFO_DEPTH   (REQUEST_FIFO_DEPTH)
	) request_net_to_core (
		.clk               (clk),
		.reset             (reset),
		.router_flit_valid (router_flit_in_valid),
		.router_flit_in    (router_flit_in),
		.packet_out        (ni_request),
		.packet_valid      (ni_request_valid),
		.packet_consumed   (dc_request_consumed),
		.stop              (ni_credit[VC_REQUEST])
	);

	ni_net_to_core #(
		.VCID         (VC_RESPONSE),
		.UNIT         (UNIT_CC),
		.BODY_W       ($bits(response_message_t)),
		.PACKET_FLITS (RESPONSE_FLITS),
		.FIFO_DEPTH   (RESPONSE_FIFO_DEPTH)
	) response_cc_net_to_core (
		.clk               (clk),
		.reset             (reset),
		.router_flit_valid (router_flit_in_valid),
		.router_flit_in    (router_flit_in),
		.packet_out        (ni_response_to_cc),
		.packet_valid      (ni_response_to_cc_valid),
		.packet_consumed   (l1d_response_to_cc_consumed),
		.stop              (cc_stop)
	);

	ni_net_to_core #(
		.VCID         (VC_RESPONSE),
		.UNIT         (UNIT_DC),
		.BODY_W       ($bits(response_message_t)),
		.PACKET_FLITS (RESPONSE_FLITS),
		.FIFO_DEPTH   (RESPONSE_FIFO_DEPTH)
	) response_dc_net_to_core (
		.clk               (clk),
		.reset             (reset),
		.router_flit_valid (router_flit_in_valid),
		.router_flit_in    (router_flit_in),
		.packet_out        (ni_response_to_dc),
		.packet_valid      (ni_response_to_dc_valid),
		.packet_consumed   (dc_response_to_dc_consumed),
		.stop              (dc_stop)
	);

	// Router cannot tell the two response units apart, so either one stops the channel
	assign ni_credit[VC_RESPONSE] = cc_stop | dc_stop;

endmodule

// File: test/network_interface_core_asserts.sv
module network_interface_core_asserts
	import ni_pkg::*;
(
	input logic                clk,
	input logic                reset,
	input flit_t               ni_flit_out,
	input logic                ni_flit_out_valid,
	input logic [VC_COUNT-1:0] router_credit,
	input logic [VC_COUNT-1:0] ni_credit
);

	// Number of failed assertions so far
	int failure_count = 0;

	// A stopped request channel gets no flit in the following cycle
	request_obeys_stop: assert property (@(posedge clk) disable iff (reset)
		ni_flit_out_valid && (ni_flit_out.vc == vc_id_t'(VC_REQUEST))
		|-> !$past(router_credit[VC_REQUEST]))
	else begin
		$error("request flit sent after router stop");
		failure_count++;
	end

	// Same for the response channel
	response_obeys_stop: assert property (@(posedge clk) disable iff (reset)
		ni_flit_out_valid && (ni_flit_out.vc == vc_id_t'(VC_RESPONSE))
		|-> !$past(router_credit[VC_RESPONSE]))
	else begin
		$error("response flit sent after router stop");
		failure_count++;
	end

	// Request packets have only HEAD and TAIL flits
	// Response packets may use all three types
	legal_flit_type: assert property (@(posedge clk) disable iff (reset)
		ni_flit_out_valid |-> ((ni_flit_out.vc == vc_id_t'(VC_REQUEST)) ?
			(ni_flit_out.flit_type inside {HEAD, TAIL}) :
			(ni_flit_out.flit_type inside {HEAD, BODY, TAIL})))
	else begin
		$error("illegal flit type on router port");
		failure_count++;
	end

	// No stop toward the router right out of reset
	credit_low_after_reset: assert property (@(posedge clk)
		$fell(reset) |-> (ni_credit == '0))
	else begin
		$error("ni_credit high after reset");
		failure_count++;
	end

endmodule

// File: test/network_interface_core_tb.sv
module network_interface_core_tb
	import ni_pkg::*;
;
	localparam int X_ADDR = 2;
	localparam int Y_ADDR = 1;
	localparam int PERIOD = 40;
	localparam int N_INJ  = 60;
	localparam int N_EJ   = 80;
	localparam longint WATCHDOG_TIME = 64'(200) * (3 * N_INJ + N_EJ) * PERIOD;

	// One injected packet as the router should see it
	typedef struct packed {
		logic [95:0]   body;
		tile_address_t dest;
		target_unit_t  target;
	} sent_packet_t;

	logic clk, reset;
	request_message_t l1d_request, ni_request;
	response_message_t l1d_response, dc_response, ni_response_to_cc, ni_response_to_dc;
	logic l1d_request_valid, l1d_response_valid, dc_response_valid;
	tile_address_t l1d_request_destination, l1d_response_destination, dc_response_destination;
	target_unit_t l1d_response_target;
	logic ni_request_network_available, ni_response_cc_network_available;
	logic ni_response_dc_network_available;
	logic ni_request_valid, ni_response_to_cc_valid, ni_response_to_dc_valid;
	logic dc_request_consumed, l1d_response_to_cc_consumed, dc_response_to_dc_consumed;
	flit_t ni_flit_out, router_flit_in;
	logic ni_flit_out_valid, router_flit_in_valid;
	logic [VC_COUNT-1:0] router_credit, ni_credit;

	sent_packet_t req_q[$], cc_q[$], dc_q[$];
	logic [95:0] ej_req_q[$], ej_cc_q[$], ej_dc_q[$];
	int mismatches, other_errors, cycle, flit_count;
	int inj_req, inj_cc, inj_dc, ej_sent, req_index, resp_index;
	logic run, resp_from_dc, saw_unavailable, saw_stop;
	// Values sampled at the falling edge for use by the stimulus
	logic s_req_avail, s_cc_avail, s_dc_avail, s_req_valid, s_cc_valid, s_dc_valid;
	logic [VC_COUNT-1:0] s_credit;
	logic [95:0] s_req_data, s_cc_data, s_dc_data;
	// Router side packet under way
	logic rt_active, rt_vc;
	int rt_index, rt_len;
	target_unit_t rt_target;
	logic [95:0] rt_body;

	network_interface_core #(.X_ADDR(X_ADDR), .Y_ADDR(Y_ADDR)) dut (.*);

	bind network_interface_core network_interface_core_asserts asserts (
		.clk(clk), .reset(reset), .ni_flit_out(ni_flit_out),
		.ni_flit_out_valid(ni_flit_out_valid), .router_credit(router_credit),
		.ni_credit(ni_credit));

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] expected);
		if (got !== expected) begin
			mismatches++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, expected);
		end
	endtask

	function automatic flit_type_t type_at(input int index, input int len);
		if (index == 0) return HEAD;
		if (index == len - 1) return TAIL;
		return BODY;
	endfunction

	// Compare one output flit with the model packet it belongs to
	task automatic check_flit(input sent_packet_t pkt, input int index, input int len);
		check_value("ni_flit_out.flit_type", ni_flit_out.flit_type, type_at(index, len));
		check_value("ni_flit_out.destination", ni_flit_out.destination, pkt.dest);
		check_value("ni_flit_out.target_unit", ni_flit_out.target_unit, pkt.target);
		check_value("ni_flit_out.payload", ni_flit_out.payload, pkt.body[index*32 +: 32]);
	endtask

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("Timeout: the run did not finish, traffic is stuck");
		$display("Test FAILED");
		$finish;
	end

	always @(negedge clk) begin
		s_req_avail = ni_request_network_available;
		s_cc_avail  = ni_response_cc_network_available;
		s_dc_avail  = ni_response_dc_network_available;
		s_credit    = ni_credit;
		s_req_valid = ni_request_valid;
		s_cc_valid  = ni_response_to_cc_valid;
		s_dc_valid  = ni_response_to_dc_valid;
		s_req_data  = {32'b0, ni_request};
		s_cc_data   = ni_response_to_cc;
		s_dc_data   = ni_response_to_dc;
		if (run && !(s_req_avail && s_cc_avail && s_dc_avail)) saw_unavailable = 1'b1;
		if (run && (|s_credit)) saw_stop = 1'b1;
		if (run && ni_flit_out_valid) begin
			flit_count++;
			if (ni_flit_out.vc == vc_id_t'(VC_REQUEST)) begin
				if (req_q.size() == 0) begin
					other_errors++;
					$display("Error at %0t: request flit sent with no request pending", $time);
				end else begin
					check_flit(req_q[0], req_index, REQUEST_FLITS);
					req_index++;
					if (req_index == REQUEST_FLITS) begin
						void'(req_q.pop_front());
						req_index = 0;
					end
				end
			end else begin
				// The head flit tells which response source owns the packet
				if (resp_index == 0) begin
					resp_from_dc = dc_q.size() > 0 && dc_q[0].body[31:0] == ni_flit_out.payload
						&& dc_q[0].dest == ni_flit_out.destination;
				end
				if ((resp_from_dc ? dc_q.size() : cc_q.size()) == 0) begin
					other_errors++;
					$display("Error at %0t: response flit sent with no response pending", $time);
				end else begin
					check_flit(resp_from_dc ? dc_q[0] : cc_q[0], resp_index, RESPONSE_FLITS);
					resp_index++;
					if (resp_index == RESPONSE_FLITS) begin
						if (resp_from_dc) void'(dc_q.pop_front());
						else void'(cc_q.pop_front());
						resp_index = 0;
					end
				end
			end
		end
	end

	always @(posedge clk) begin
		logic stall;
		sent_packet_t pkt;
		if (run) begin
			// Seed once on the first stimulus cycle
			if (cycle == 0) begin
				void'($urandom(32'hdcb6_8101));
			end
			cycle++;
			// Long stretch with the router and the tile both stopped
			stall = (cycle >= 100) && (cycle < 500);
			router_credit <= stall ? 2'b11 : VC_COUNT'($urandom_range(3) == 0 ? $urandom : 0);
			// Each source injects one packet and then skips a cycle so availability is never stale
			l1d_request_valid <= 1'b0;
			if (!l1d_request_valid && s_req_avail && inj_req < N_INJ && $urandom_range(5) == 0) begin
				pkt = '{body: {32'b0, $urandom, $urandom}, dest: tile_address_t'($urandom),
					target: UNIT_DC};
				req_q.push_back(pkt);
				l1d_request <= request_message_t'(pkt.body[63:0]);
				l1d_request_destination <= pkt.dest;
				l1d_request_valid <= 1'b1;
				inj_req++;
			end
			l1d_response_valid <= 1'b0;
			if (!l1d_response_valid && s_cc_avail && inj_cc < N_INJ && $urandom_range(5) == 0) begin
				pkt = '{body: {$urandom, $urandom, $urandom}, dest: tile_address_t'($urandom),
					target: target_unit_t'($urandom_range(1))};
				cc_q.push_back(pkt);
				l1d_response <= response_message_t'(pkt.body);
				l1d_response_destination <= pkt.dest;
				l1d_response_target <= pkt.target;
				l1d_response_valid <= 1'b1;
				inj_cc++;
			end
			dc_response_valid <= 1'b0;
			if (!dc_response_valid && s_dc_avail && inj_dc < N_INJ && $urandom_range(5) == 0) begin
				pkt = '{body: {$urandom, $urandom, $urandom}, dest: tile_address_t'($urandom),
					target: UNIT_CC};
				dc_q.push_back(pkt);
				dc_response <= response_message_t'(pkt.body);
				dc_response_destination <= pkt.dest;
				dc_response_valid <= 1'b1;
				inj_dc++;
			end
			// Consumed packets are checked against what the router side sent
			dc_request_consumed <= 1'b0;
			if (!stall && !dc_request_consumed && s_req_valid && $urandom_range(2) == 0) begin
				check_value("ni_request", s_req_data,
					ej_req_q.size() ? ej_req_q.pop_front() : 'x);
				dc_request_consumed <= 1'b1;
			end
			l1d_response_to_cc_consumed <= 1'b0;
			if (!stall && !l1d_response_to_cc_consumed && s_cc_valid && $urandom_range(2) == 0) begin
				check_value("ni_response_to_cc", s_cc_data,
					ej_cc_q.size() ? ej_cc_q.pop_front() : 'x);
				l1d_response_to_cc_consumed <= 1'b1;
			end
			dc_response_to_dc_consumed <= 1'b0;
			if (!stall && !dc_response_to_dc_consumed && s_dc_valid && $urandom_range(2) == 0) begin
				check_value("ni_response_to_dc", s_dc_data,
					ej_dc_q.size() ? ej_dc_q.pop_front() : 'x);
				dc_response_to_dc_consumed <= 1'b1;
			end
			// A new router packet only starts while its channel is not stopped
			router_flit_in_valid <= 1'b0;
			if (!rt_active && ej_sent < N_EJ && $urandom_range(3) == 0) begin
				rt_vc = 1'($urandom_range(1));
				if (!s_credit[rt_vc]) begin
					rt_active = 1'b1;
					rt_index  = 0;
					rt_len    = rt_vc ? RESPONSE_FLITS : REQUEST_FLITS;
					rt_target = rt_vc ? target_unit_t'($urandom_range(1)) : UNIT_DC;
					rt_body   = {rt_vc ? $urandom : 32'b0, $urandom, $urandom};
					if (!rt_vc) ej_req_q.push_back(rt_body);
					else if (rt_target == UNIT_CC) ej_cc_q.push_back(rt_body);
					else ej_dc_q.push_back(rt_body);
					ej_sent++;
				end
			end
			if (rt_active && (rt_index == 0 || $urandom_range(3) != 0)) begin
				router_flit_in <= '{flit_type: type_at(rt_index, rt_len), vc: rt_vc,
					destination: '{x: 2'(X_ADDR), y: 2'(Y_ADDR)}, target_unit: rt_target,
					payload: rt_body[rt_index*32 +: 32]};
				router_flit_in_valid <= 1'b1;
				rt_index++;
				if (rt_index == rt_len) rt_active = 1'b0;
			end
		end
	end

	initial begin
		{mismatches, other_errors, cycle, flit_count} = '0;
		{inj_req, inj_cc, inj_dc, ej_sent, req_index, resp_index} = '0;
		{run, resp_from_dc, saw_unavailable, saw_stop, rt_active} = '0;
		reset = 1'b1;
		{l1d_request, l1d_response, dc_response} = '0;
		{l1d_request_valid, l1d_response_valid, dc_response_valid} = '0;
		{l1d_request_destination, l1d_response_destination, dc_response_destination} = '0;
		l1d_response_target = UNIT_CC;
		{dc_request_consumed, l1d_response_to_cc_consumed, dc_response_to_dc_consumed} = '0;
		router_flit_in = '0;
		router_flit_in_valid = 1'b0;
		router_credit = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		run <= 1'b1;
		@(negedge clk);
		// Idle state right after reset
		check_value("valid outputs", {ni_request_valid, ni_response_to_cc_valid,
			ni_response_to_dc_valid, ni_flit_out_valid}, 4'b0);
		check_value("network_available", {ni_request_network_available,
			ni_response_cc_network_available, ni_response_dc_network_available}, 3'b111);
		check_value("ni_credit", ni_credit, 2'b0);
		while (inj_req + inj_cc + inj_dc < 3 * N_INJ || ej_sent < N_EJ || rt_active
				|| req_q.size() || cc_q.size() || dc_q.size()
				|| ej_req_q.size() || ej_cc_q.size() || ej_dc_q.size()) begin
			@(negedge clk);
		end
		repeat (5) @(negedge clk);
		check_value("flit count", flit_count, N_INJ * (REQUEST_FLITS + 2 * RESPONSE_FLITS));
		if (!saw_unavailable) begin
			other_errors++;
			$display("Error: network_available never dropped while the router was stopped");
		end
		if (!saw_stop) begin
			other_errors++;
			$display("Error: ni_credit never rose while consumption was withheld");
		end
		if (dut.asserts.failure_count != 0) begin
			other_errors += dut.asserts.failure_count;
			$display("Error: %0d assertions on the router port failed",
				dut.asserts.failure_count);
		end
		$display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: network_interface_core.f
hw/ni_pkg.sv
hw/ni_packet_fifo.sv
hw/ni_round_robin_arbiter.sv
hw/ni_core_to_net.sv
hw/ni_net_to_core.sv
hw/network_interface_core.sv
test/network_interface_core_asserts.sv
test/network_interface_core_tb.sv
